// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		--top-module l1b_ch_subsys_tb -Mdir obj_dir -f l1b_ch_subsys.f
	./obj_dir/Vl1b_ch_subsys_tb | tee sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== dv/l1b_ch_subsys_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module l1b_ch_subsys_tb
   import l1b_pkg::*;
();

   localparam int CNT_W  = 5;
   localparam int SEED   = 12747;
   localparam int N_CB   = 32;
   localparam int N_PAIR = 3;
   localparam int N_MIX  = 4;
   // fill, cubank pairs, burst beats, mixed bursts, readback, busy test
   localparam int N_OPS  = 2 * RAM_DEPTH + 2 * N_CB + 32 * N_PAIR + 32 * N_MIX + 19;

   logic       clk;
   logic       rst_n;
   ram_req_t   cubank_req;
   ram_rsp_t   cubank_rsp;
   ram_rsp_t   tcache_rsp;
   logic       burst_start;
   logic       burst_we;
   addr_t      burst_addr;
   burst_len_t burst_len;
   data_t      burst_wdata = '0;
   mask_t      burst_wmask = '0;
   logic       burst_wdata_take;
   logic       burst_busy;
   logic       burst_done;

   // reference memory and expected returns
   data_t      ref_mem [RAM_DEPTH];
   data_t      cq_data [$];
   longint     cq_cyc [$];
   data_t      tq_data [$];
   data_t      bw_data [16];
   mask_t      bw_mask [16];
   longint     cyc = 0;
   int         wr_beats = 0;
   int         done_cnt = 0;
   int         n_starts = 0;
   logic       done_prev = 1'b0;
   logic       tc_we = 1'b0;
   addr_t      tc_addr = '0;
   burst_len_t tc_len = '0;
   logic       mix_stop;
   addr_t      mix_base;
   burst_len_t mix_len;

   l1b_clk_gen u_clk_gen (.clk (clk), .rst_n (rst_n));

   l1b_ch_subsys #(.CNT_W (CNT_W)) dut0 (
      .clk              (clk),
      .rst_n            (rst_n),
      .cubank_req       (cubank_req),
      .cubank_rsp       (cubank_rsp),
      .burst_start      (burst_start),
      .burst_we         (burst_we),
      .burst_addr       (burst_addr),
      .burst_len        (burst_len),
      .burst_wdata      (burst_wdata),
      .burst_wmask      (burst_wmask),
      .burst_wdata_take (burst_wdata_take),
      .burst_busy       (burst_busy),
      .burst_done       (burst_done),
      .tcache_rsp       (tcache_rsp)
   );

   // lanes with a set mask bit take the new byte
   function automatic data_t merge_word(input data_t old, input data_t wd, input mask_t m);
      data_t res;
      res = old;
      for (int i = 0; i < LB_CH; i++) begin
         if (m[i]) res[i] = wd[i];
      end
      return res;
   endfunction

   function automatic data_t rand_word();
      return {$urandom, $urandom, $urandom, $urandom};
   endfunction

   function automatic logic in_window(input addr_t a);
      return addr_t'(a - mix_base) < addr_t'(mix_len);
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Simulation FAILED");
      $fatal(1);
   endtask

   task automatic check_val(input string name, input logic [127:0] got,
                            input logic [127:0] exp);
      if (got !== exp) begin
         $display("error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
         $display("Simulation FAILED");
         $fatal(1);
      end
   endtask

   task automatic cb_drive(input logic cs, input logic we, input addr_t a,
                           input data_t d, input mask_t m);
      @(posedge clk);
      cubank_req <= '{cs: cs, we: we, addr: a, wdata: d, bitmask: m};
   endtask

   task automatic cb_idle();
      cb_drive(1'b0, 1'b0, '0, '0, '0);
   endtask

   task automatic burst_go(input logic we, input addr_t a, input burst_len_t len);
      for (int i = 0; i < 16; i++) begin
         bw_data[i] = rand_word();
         bw_mask[i] = mask_t'($urandom);
      end
      @(posedge clk);
      burst_start <= 1'b1;
      burst_we    <= we;
      burst_addr  <= a;
      burst_len   <= len;
      @(posedge clk);
      burst_start <= 1'b0;
      n_starts++;
   endtask

   task automatic wait_done();
      int n;
      n = 0;
      while (done_cnt < n_starts) begin
         @(posedge clk);
         n++;
         if (n > 1000) abort_run("burst_done did not arrive within 1000 cycles");
      end
   endtask

   always @(posedge clk) begin
      cyc <= cyc + 1;
   end

   // next write word goes out after each taken beat
   always @(posedge clk) begin
      burst_wdata <= bw_data[wr_beats % 16];
      burst_wmask <= bw_mask[wr_beats % 16];
   end

   // compare process, sampled mid-cycle
   always @(negedge clk) begin
      if (rst_n) begin
         if (cubank_rsp.rvalid) begin
            if (cq_data.size() == 0) begin
               check_val("cubank_rsp.rvalid", 1'b1, 1'b0);
            end else begin
               check_val("cubank_rsp return cycle", cyc, cq_cyc.pop_front());
               check_val("cubank_rsp.rdata", cubank_rsp.rdata, cq_data.pop_front());
            end
         end else if (cq_cyc.size() != 0 && cq_cyc[0] <= cyc) begin
            check_val("cubank_rsp.rvalid", 1'b0, 1'b1);
         end
         if (tcache_rsp.rvalid) begin
            if (tq_data.size() == 0) begin
               check_val("tcache_rsp.rvalid", 1'b1, 1'b0);
            end else begin
               check_val("tcache_rsp.rdata", tcache_rsp.rdata, tq_data.pop_front());
            end
         end
         // cubank always wins, accepted at the next edge and back two edges later
         if (cubank_req.cs) begin
            if (cubank_req.we) begin
               ref_mem[cubank_req.addr] = merge_word(ref_mem[cubank_req.addr],
                                                     cubank_req.wdata, cubank_req.bitmask);
            end else begin
               cq_data.push_back(ref_mem[cubank_req.addr]);
               cq_cyc.push_back(cyc + 3);
            end
         end
         if (burst_wdata_take) begin
            ref_mem[tc_addr] = merge_word(ref_mem[tc_addr], burst_wdata, burst_wmask);
            tc_addr  = tc_addr + 1'b1;
            wr_beats = wr_beats + 1;
         end
         if (burst_start && !burst_busy) begin
            tc_we    = burst_we;
            tc_addr  = burst_addr;
            tc_len   = burst_len;
            wr_beats = 0;
            // read bursts return in address order
            for (int i = 0; i < burst_len; i++) begin
               if (!burst_we) tq_data.push_back(ref_mem[addr_t'(burst_addr + i)]);
            end
         end
         if (burst_done) begin
            check_val("burst_done pulse length", done_prev, 1'b0);
            if (tc_we) check_val("tcache write beats", wr_beats, tc_len);
            else check_val("tcache reads left at burst_done", tq_data.size(), 0);
            done_cnt = done_cnt + 1;
         end
         done_prev = burst_done;
      end
   end

   initial begin
      repeat (N_OPS * 40) @(posedge clk);
      abort_run($sformatf("watchdog: run did not finish within %0d cycles", N_OPS * 40));
   end

   initial begin
      addr_t      a;
      addr_t      cb_addr [8];
      burst_len_t len;
      void'($urandom(SEED));
      cubank_req  = '0;
      burst_start = 1'b0;
      burst_we    = 1'b0;
      burst_addr  = '0;
      burst_len   = 5'd1;
      mix_stop    = 1'b0;
      mix_base    = '0;
      mix_len     = '0;
      for (int i = 0; i < 16; i++) begin
         bw_data[i] = '0;
         bw_mask[i] = '0;
      end
      @(posedge rst_n);
      @(negedge clk);
      check_val("cubank_rsp.rvalid", cubank_rsp.rvalid, 1'b0);
      check_val("tcache_rsp.rvalid", tcache_rsp.rvalid, 1'b0);
      check_val("burst_busy", burst_busy, 1'b0);
      check_val("burst_done", burst_done, 1'b0);
      check_val("burst_wdata_take", burst_wdata_take, 1'b0);

      // known contents everywhere first
      for (int i = 0; i < RAM_DEPTH; i++) cb_drive(1'b1, 1'b1, addr_t'(i), rand_word(), '1);

      // masked writes, then back-to-back reads
      for (int j = 0; j < N_CB; j += 8) begin
         for (int i = 0; i < 8; i++) begin
            cb_addr[i] = addr_t'($urandom);
            cb_drive(1'b1, 1'b1, cb_addr[i], rand_word(), mask_t'($urandom));
         end
         for (int i = 0; i < 8; i++) cb_drive(1'b1, 1'b0, cb_addr[i], '0, '0);
         cb_idle();
      end

      // first pair wraps past the top address
      for (int j = 0; j < N_PAIR; j++) begin
         a   = (j == 0) ? 8'hf8 : addr_t'($urandom);
         len = burst_len_t'($urandom_range(16, 1));
         burst_go(1'b1, a, len);
         wait_done();
         burst_go(1'b0, a, len);
         wait_done();
      end

      // cubank traffic stalls the bursts, writes kept out of the burst window
      for (int j = 0; j < N_MIX; j++) begin
         mix_base = addr_t'($urandom);
         mix_len  = burst_len_t'($urandom_range(16, 1));
         mix_stop = 1'b0;
         fork
            begin
               burst_go(1'b1, mix_base, mix_len);
               wait_done();
               burst_go(1'b0, mix_base, mix_len);
               wait_done();
               mix_stop = 1'b1;
            end
            while (!mix_stop) begin
               a = addr_t'($urandom);
               case ($urandom_range(3))
                  0, 1: cb_idle();
                  2: cb_drive(1'b1, 1'b0, a, '0, '0);
                  default: begin
                     if (in_window(a)) cb_idle();
                     else cb_drive(1'b1, 1'b1, a, rand_word(), mask_t'($urandom));
                  end
               endcase
            end
         join
         cb_idle();
      end

      // whole memory against the model
      for (int i = 0; i < RAM_DEPTH; i++) cb_drive(1'b1, 1'b0, addr_t'(i), '0, '0);
      cb_idle();

      // second start lands while busy
      burst_go(1'b1, addr_t'($urandom), 5'd16);
      @(negedge clk);
      check_val("burst_busy", burst_busy, 1'b1);
      @(posedge clk);
      burst_start <= 1'b1;
      burst_we    <= 1'b0;
      burst_addr  <= addr_t'($urandom);
      burst_len   <= 5'd3;
      @(posedge clk);
      burst_start <= 1'b0;
      wait_done();

      repeat (40) @(posedge clk);
      check_val("burst_done count", done_cnt, n_starts);
      check_val("cubank returns outstanding", cq_data.size(), 0);
      check_val("tcache returns outstanding", tq_data.size(), 0);
      $display("Simulation PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== dv/l1b_clk_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module l1b_clk_gen #(
   parameter int PERIOD_NS  = 10,
   parameter int RST_CYCLES = 4
) (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   // released on a rising edge after the reset cycles
   initial begin
      rst_n = 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
   end

endmodule

`default_nettype wire

// ==== l1b_ch_subsys.f ====
verilog/l1b_pkg.sv
verilog/std_spram256x128_b16.sv
verilog/l1b_ch_ram_wrapper.sv
verilog/l1b_beat_counter.sv
verilog/l1b_tcache_burst_fsm.sv
verilog/l1b_ch_subsys.sv
dv/l1b_clk_gen.sv
dv/l1b_ch_subsys_tb.sv

// ==== verilog/l1b_beat_counter.sv ====
`timescale 1ns/100ps
`default_nettype none

module l1b_beat_counter #(
   parameter int CNT_W = 5
) (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             load,
   input  logic [CNT_W-1:0] load_val,
   input  logic             dec,
   output logic [CNT_W-1:0] count,
   output logic             last
);

   logic [CNT_W-1:0] count_q;

   // load wins over dec
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         count_q <= '0;
      end else if (load) begin
         count_q <= load_val;
      end else if (dec) begin
         count_q <= count_q - 1'b1;
      end
   end

   assign count = count_q;

   // one beat left
   assign last = (count_q == CNT_W'(1));

   // underflow means a beat was counted twice
   a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
      (dec && !load) |-> (count_q != '0))
      else $error("beat counter decremented at zero");

endmodule

`default_nettype wire

// ==== verilog/l1b_ch_ram_wrapper.sv ====
`timescale 1ns/100ps
`default_nettype none

module l1b_ch_ram_wrapper
   import l1b_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  ram_req_t cubank_req,
   input  ram_req_t tcache_req,
   output logic     tcache_grant,
   output ram_rsp_t cubank_rsp,
   output ram_rsp_t tcache_rsp
);

   ram_req_t   ram_sel;
   data_t      ram_bweb;
   data_t      ram_q;
   logic       rd_acc;
   // one read-in-flight bit per stage
   logic [1:0] rd_vld_q;
   // 1 marks a cubank read in that stage
   logic [1:0] rd_src_q;
   logic       cubank_rvalid_q;
   logic       tcache_rvalid_q;
   data_t      rdata_s1_q;
   data_t      rdata_q;

   // cubank always wins the port
   assign ram_sel      = cubank_req.cs ? cubank_req : tcache_req;
   assign tcache_grant = tcache_req.cs & ~cubank_req.cs;
   assign rd_acc       = ram_sel.cs & ~ram_sel.we;

   // byte mask to active-low bit mask
   always_comb begin
      for (int i = 0; i < LB_CH; i++) begin
         ram_bweb[i] = {WORD_W{~ram_sel.bitmask[i]}};
      end
   end

   std_spram256x128_b16 u_ram (
      .clk  (clk),
      .ceb  (~ram_sel.cs),
      .web  (~ram_sel.we),
      .a    (ram_sel.addr),
      .d    (ram_sel.wdata),
      .q    (ram_q),
      .bweb (ram_bweb)
   );

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_vld_q        <= '0;
         rd_src_q        <= '0;
         cubank_rvalid_q <= 1'b0;
         tcache_rvalid_q <= 1'b0;
      end else begin
         rd_vld_q        <= {rd_vld_q[0], rd_acc};
         rd_src_q        <= {rd_src_q[0], cubank_req.cs};
         cubank_rvalid_q <= rd_vld_q[1] & rd_src_q[1];
         tcache_rvalid_q <= rd_vld_q[1] & ~rd_src_q[1];
      end
   end

   // two data stages so back-to-back reads don't overwrite each other
   always_ff @(posedge clk) begin
      if (rd_vld_q[0]) begin
         rdata_s1_q <= ram_q;
      end
      if (rd_vld_q[1]) begin
         rdata_q <= rdata_s1_q;
      end
   end

   // both get the same word and the strobe picks the owner
   assign cubank_rsp.rvalid = cubank_rvalid_q;
   assign cubank_rsp.rdata  = rdata_q;
   assign tcache_rsp.rvalid = tcache_rvalid_q;
   assign tcache_rsp.rdata  = rdata_q;

   a_one_owner: assert property (@(posedge clk) disable iff (!rst_n)
      !(cubank_rsp.rvalid && tcache_rsp.rvalid))
      else $error("cubank and tcache rvalid both high");

endmodule

`default_nettype wire

// ==== verilog/l1b_ch_subsys.sv ====
`timescale 1ns/100ps
`default_nettype none

module l1b_ch_subsys
   import l1b_pkg::*;
#(
   parameter int CNT_W = 5
) (
   input  logic       clk,
   input  logic       rst_n,
   input  ram_req_t   cubank_req,
   output ram_rsp_t   cubank_rsp,
   input  logic       burst_start,
   input  logic       burst_we,
   input  addr_t      burst_addr,
   input  burst_len_t burst_len,
   input  data_t      burst_wdata,
   input  mask_t      burst_wmask,
   output logic       burst_wdata_take,
   output logic       burst_busy,
   output logic       burst_done,
   output ram_rsp_t   tcache_rsp
);

   ram_req_t         tcache_req;
   logic             tcache_grant;
   logic             issue_load;
   logic             issue_dec;
   logic             issue_last;
   logic             ret_load;
   logic             ret_dec;
   logic             ret_last;
   logic [CNT_W-1:0] cnt_load_val;

   // both counters start from the burst length
   assign cnt_load_val = CNT_W'(burst_len);

   l1b_tcache_burst_fsm #(.CNT_W(CNT_W)) u_burst_fsm (
      .clk              (clk),
      .rst_n            (rst_n),
      .start            (burst_start),
      .start_we         (burst_we),
      .start_addr       (burst_addr),
      .start_len        (burst_len),
      .wdata            (burst_wdata),
      .wmask            (burst_wmask),
      .tcache_grant     (tcache_grant),
      .tcache_rsp_valid (tcache_rsp.rvalid),
      .issue_last       (issue_last),
      .ret_last         (ret_last),
      .issue_load       (issue_load),
      .issue_dec        (issue_dec),
      .ret_load         (ret_load),
      .ret_dec          (ret_dec),
      .tcache_req       (tcache_req),
      .wdata_take       (burst_wdata_take),
      .busy             (burst_busy),
      .burst_done       (burst_done)
   );

   // beats still to issue
   l1b_beat_counter #(.CNT_W(CNT_W)) u_issue_cnt (
      .clk (clk), .rst_n (rst_n), .load (issue_load), .load_val (cnt_load_val),
      .dec (issue_dec), .count (), .last (issue_last)
   );

   // beats still to retire
   l1b_beat_counter #(.CNT_W(CNT_W)) u_ret_cnt (
      .clk (clk), .rst_n (rst_n), .load (ret_load), .load_val (cnt_load_val),
      .dec (ret_dec), .count (), .last (ret_last)
   );

   l1b_ch_ram_wrapper u_ram_wrap (
      .clk          (clk),
      .rst_n        (rst_n),
      .cubank_req   (cubank_req),
      .tcache_req   (tcache_req),
      .tcache_grant (tcache_grant),
      .cubank_rsp   (cubank_rsp),
      .tcache_rsp   (tcache_rsp)
   );

endmodule

`default_nettype wire

// ==== verilog/l1b_pkg.sv ====
`default_nettype none

package l1b_pkg;

   // channel geometry
   localparam int LB_CH     = 16;
   localparam int WORD_W    = 8;
   localparam int ADDR_W    = 8;
   localparam int BLEN_W    = 5;
   localparam int RAM_DEPTH = 256;

   // one byte lane
   typedef logic [WORD_W-1:0] word_t;

   // full channel word, lane 0 in the low byte
   typedef word_t [LB_CH-1:0] data_t;

   // byte write enables, 1 writes the lane
   typedef logic [LB_CH-1:0] mask_t;

   typedef logic [ADDR_W-1:0] addr_t;

   // burst length in beats, 1 to 16
   typedef logic [BLEN_W-1:0] burst_len_t;

   // one port request, same shape for cubank and burst engine
   typedef struct packed {
      logic  cs;
      logic  we;
      addr_t addr;
      data_t wdata;
      mask_t bitmask;
   } ram_req_t;

   // read return towards one requester
   typedef struct packed {
      logic  rvalid;
      data_t rdata;
   } ram_rsp_t;

   typedef enum logic [1:0] {
      ST_IDLE  = 2'd0,
      ST_ISSUE = 2'd1,
      ST_DRAIN = 2'd2
   } burst_state_t;

endpackage

`default_nettype wire

// ==== verilog/l1b_tcache_burst_fsm.sv ====
`timescale 1ns/100ps
`default_nettype none

module l1b_tcache_burst_fsm
   import l1b_pkg::*;
#(
   parameter int CNT_W = 5
) (
   input  logic       clk,
   input  logic       rst_n,
   input  logic       start,
   input  logic       start_we,
   input  addr_t      start_addr,
   input  burst_len_t start_len,
   input  data_t      wdata,
   input  mask_t      wmask,
   input  logic       tcache_grant,
   input  logic       tcache_rsp_valid,
   input  logic       issue_last,
   input  logic       ret_last,
   output logic       issue_load,
   output logic       issue_dec,
   output logic       ret_load,
   output logic       ret_dec,
   output ram_req_t   tcache_req,
   output logic       wdata_take,
   output logic       busy,
   output logic       burst_done
);

   burst_state_t state_q;
   burst_state_t state_d;
   logic         we_q;
   addr_t        addr_q;
   logic         start_ok;
   logic         beat_ok;
   logic         burst_done_q;

   // start only counts in idle
   assign start_ok = start & (state_q == ST_IDLE);

   // beat taken by the port
   assign beat_ok = (state_q == ST_ISSUE) & tcache_grant;

   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_IDLE: begin
            if (start) state_d = ST_ISSUE;
         end
         ST_ISSUE: begin
            if (beat_ok && issue_last) state_d = ST_DRAIN;
         end
         ST_DRAIN: begin
            // done pulse is the last drain cycle
            if (burst_done_q) state_d = ST_IDLE;
         end
         default: state_d = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q      <= ST_IDLE;
         we_q         <= 1'b0;
         addr_q       <= '0;
         burst_done_q <= 1'b0;
      end else begin
         state_q      <= state_d;
         burst_done_q <= ret_dec & ret_last;
         if (start_ok) begin
            we_q   <= start_we;
            addr_q <= start_addr;
         end else if (beat_ok) begin
            // 8-bit address wraps at 255
            addr_q <= addr_q + addr_t'(1);
         end
      end
   end

   // counter strobes
   assign issue_load = start_ok;
   assign ret_load   = start_ok;
   assign issue_dec  = beat_ok;
   // writes retire at grant, reads at return
   assign ret_dec    = busy & (we_q ? beat_ok : tcache_rsp_valid);

   // request held stable until granted
   assign tcache_req.cs      = (state_q == ST_ISSUE);
   assign tcache_req.we      = we_q;
   assign tcache_req.addr    = addr_q;
   assign tcache_req.wdata   = wdata;
   assign tcache_req.bitmask = wmask;

   assign wdata_take = beat_ok & we_q;
   assign busy       = (state_q != ST_IDLE);
   assign burst_done = burst_done_q;

   a_start_len: assert property (@(posedge clk) disable iff (!rst_n)
      start_ok |-> (start_len != '0) &&
                   (start_len <= burst_len_t'(1 << (CNT_W - 1))))
      else $error("illegal burst length %0d", start_len);

endmodule

`default_nettype wire

// ==== verilog/std_spram256x128_b16.sv ====
`timescale 1ns/100ps
`default_nettype none

module std_spram256x128_b16
   import l1b_pkg::*;
(
   input  logic  clk,
   input  logic  ceb,
   input  logic  web,
   input  addr_t a,
   input  data_t d,
   output data_t q,
   input  data_t bweb
);

   data_t mem [RAM_DEPTH];

   // write keeps the bits whose bweb is high
   always_ff @(posedge clk) begin
      if (!ceb && !web) begin
         mem[a] <= (mem[a] & bweb) | (d & ~bweb);
      end
   end

   // read port, q holds between reads
   always_ff @(posedge clk) begin
      if (!ceb && web) begin
         q <= mem[a];
      end
   end

   // macro only has a write mask on writes
   a_bweb_known: assert property (@(posedge clk)
      (!ceb && !web) |-> !$isunknown(bweb))
      else $error("bweb unknown on write to %0d", a);

   // a write never targets an unknown word
   a_addr_known: assert property (@(posedge clk)
      !ceb |-> !$isunknown(a))
      else $error("address unknown with ceb low");

endmodule

`default_nettype wire
